//--- Bender.yml
package:
  name: afu_port_complex

sources:
  # packages first, then the pipeline stages and the top level
  - files:
      - hdl/afu_hdr_pkg.sv
      - hdl/port_cfg_pkg.sv
      - hdl/req_decoder.sv
      - hdl/he_lb_engine.sv
      - hdl/he_mem_engine.sv
      - hdl/port_afu_instances.sv
      - hdl/cpl_builder.sv
      - hdl/afu_top.sv
  - target: test
    files:
      - verif/tb_afu_top.sv

//--- hdl/afu_hdr_pkg.sv
`default_nettype none

package afu_hdr_pkg;

   // ============================================================
   // request and completion field widths
   // ============================================================

   // the tag comes back unchanged on either outbound channel
   localparam int tag_w  = 8;
   localparam int data_w = 32;
   // the engines only look at the low bits of the address
   localparam int addr_w = 8;

   // ============================================================
   // opcode and completion status encodings
   // ============================================================

   // all four codes are legal on the wire, so each engine decides what it supports
   typedef enum logic [1:0] {
      op_rd   = 2'd0,
      op_wr   = 2'd1,
      op_echo = 2'd2,
      op_fadd = 2'd3
   } opcode_t;

   // st_ok must stay at zero because the port merge ORs the engine statuses
   typedef enum logic [1:0] {
      st_ok       = 2'd0,
      st_ur       = 2'd1,
      st_bad_port = 2'd2
   } status_t;

endpackage : afu_hdr_pkg

`default_nettype wire

//--- hdl/afu_top.sv
`default_nettype none
`timescale 1ns/1ns

module afu_top
   import afu_hdr_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            req_valid,
   input  logic [port_cfg_pkg::port_w-1:0] req_port,
   input  opcode_t                         req_op,
   input  logic [addr_w-1:0]               req_addr,
   input  logic [data_w-1:0]               req_data,
   input  logic [tag_w-1:0]                req_tag,
   output logic                            cpl_valid,
   output logic [tag_w-1:0]                cpl_tag,
   output status_t                         cpl_status,
   output logic [data_w-1:0]               cpl_data,
   output logic                            commit_valid,
   output logic [tag_w-1:0]                commit_tag
);

   // stage 1 to stage 2
   logic                               dec_valid;
   logic [port_cfg_pkg::num_ports-1:0] dec_sel;
   logic                               dec_err;
   opcode_t                            dec_op;
   logic [addr_w-1:0]                  dec_addr;
   logic [data_w-1:0]                  dec_data;
   logic [tag_w-1:0]                   dec_tag;

   // stage 2 to stage 3
   logic              exe_valid;
   opcode_t           exe_op;
   status_t           exe_status;
   logic [data_w-1:0] exe_data;
   logic [tag_w-1:0]  exe_tag;

   req_decoder i_dec (
      .clk, .rst, .req_valid, .req_port, .req_op, .req_addr, .req_data, .req_tag,
      .dec_valid, .dec_sel, .dec_err, .dec_op, .dec_addr, .dec_data, .dec_tag
   );

   port_afu_instances i_ports (
      .clk, .rst, .dec_valid, .dec_sel, .dec_err, .dec_op, .dec_addr, .dec_data,
      .dec_tag, .exe_valid, .exe_op, .exe_status, .exe_data, .exe_tag
   );

   cpl_builder i_cpl (
      .clk, .rst, .exe_valid, .exe_op, .exe_status, .exe_data, .exe_tag,
      .cpl_valid, .cpl_tag, .cpl_status, .cpl_data, .commit_valid, .commit_tag
   );

endmodule : afu_top

`default_nettype wire

//--- hdl/cpl_builder.sv
`default_nettype none
`timescale 1ns/1ns

module cpl_builder
   import afu_hdr_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              exe_valid,
   input  opcode_t           exe_op,
   input  status_t           exe_status,
   input  logic [data_w-1:0] exe_data,
   input  logic [tag_w-1:0]  exe_tag,
   output logic              cpl_valid,
   output logic [tag_w-1:0]  cpl_tag,
   output status_t           cpl_status,
   output logic [data_w-1:0] cpl_data,
   output logic              commit_valid,
   output logic [tag_w-1:0]  commit_tag
);

   logic is_commit;
   logic is_ok;

   // ============================================================
   // channel routing
   // ============================================================

   assign is_ok = exe_status == st_ok;

   // only a write that an engine accepted becomes a commit on channel B
   // a write to a bad port still gets an error completion on channel A
   assign is_commit = exe_valid && is_ok && (exe_op == op_wr);

   always_ff @(posedge clk) begin
      if (rst) begin
         cpl_valid    <= 1'b0;
         commit_valid <= 1'b0;
      end else begin
         cpl_valid    <= exe_valid && !is_commit;
         commit_valid <= is_commit;
      end
   end

   // ============================================================
   // completion fields
   // ============================================================

   // both channels return the request tag
   always_ff @(posedge clk) begin
      cpl_tag    <= exe_tag;
      commit_tag <= exe_tag;
      cpl_status <= exe_status;
      // an error completion never carries data
      if (is_ok) begin
         cpl_data <= exe_data;
      end else begin
         cpl_data <= '0;
      end
   end

   // each engine result leaves on exactly one channel one cycle later
   a_one_channel : assert property (@(posedge clk) disable iff (rst)
      exe_valid |=> cpl_valid ^ commit_valid);

   a_no_spurious : assert property (@(posedge clk) disable iff (rst)
      !exe_valid |=> !cpl_valid && !commit_valid);

endmodule : cpl_builder

`default_nettype wire

//--- hdl/he_lb_engine.sv
`default_nettype none
`timescale 1ns/1ns

module he_lb_engine
   import afu_hdr_pkg::*, port_cfg_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              sel,
   input  opcode_t           op,
   input  logic [addr_w-1:0] addr,
   input  logic [data_w-1:0] data,
   input  logic [tag_w-1:0]  tag,
   output logic              rsp_valid,
   output status_t           rsp_status,
   output logic [data_w-1:0] rsp_data,
   output logic [tag_w-1:0]  rsp_tag
);

   logic [data_w-1:0]                scratch [num_scratch];
   logic [$clog2(num_scratch)-1:0]   idx;

   // the scratch registers are picked by the low address bits
   assign idx = addr[$clog2(num_scratch)-1:0];

   // ============================================================
   // scratch register file
   // ============================================================

   // reset clears the scratch registers so the first read returns zero
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < num_scratch; i++) begin
            scratch[i] <= '0;
         end
      end else if (sel && (op == op_wr)) begin
         scratch[idx] <= data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= sel;
      end
   end

   // the response is captured every cycle, and the port merge
   // masks it with rsp_valid
   always_ff @(posedge clk) begin
      rsp_tag <= tag;
      unique case (op)
         op_rd: begin
            rsp_status <= st_ok;
            rsp_data   <= scratch[idx];
         end
         op_wr: begin
            rsp_status <= st_ok;
            rsp_data   <= '0;
         end
         op_echo: begin
            rsp_status <= st_ok;
            rsp_data   <= data;
         end
         // fetch-add is a memory exerciser operation
         default: begin
            rsp_status <= st_ur;
            rsp_data   <= '0;
         end
      endcase
   end

endmodule : he_lb_engine

`default_nettype wire

//--- hdl/he_mem_engine.sv
`default_nettype none
`timescale 1ns/1ns

module he_mem_engine
   import afu_hdr_pkg::*, port_cfg_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              sel,
   input  opcode_t           op,
   input  logic [addr_w-1:0] addr,
   input  logic [data_w-1:0] data,
   input  logic [tag_w-1:0]  tag,
   output logic              rsp_valid,
   output status_t           rsp_status,
   output logic [data_w-1:0] rsp_data,
   output logic [tag_w-1:0]  rsp_tag
);

   logic [data_w-1:0] mem [mem_depth];
   logic [mem_aw-1:0] idx;
   logic [data_w-1:0] rd_word;

   // the upper address bits are ignored, so the RAM aliases across the address space
   assign idx     = addr[mem_aw-1:0];
   assign rd_word = mem[idx];

   // ============================================================
   // local RAM with write and fetch-add
   // ============================================================

   // reset walks all words and clears them
   // fetch-add reads the old word and writes the sum in the same cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < mem_depth; i++) begin
            mem[i] <= '0;
         end
      end else if (sel) begin
         if (op == op_wr) begin
            mem[idx] <= data;
         end else if (op == op_fadd) begin
            mem[idx] <= rd_word + data;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= sel;
      end
   end

   // read and fetch-add both return the word as it was before this cycle's update
   always_ff @(posedge clk) begin
      rsp_tag <= tag;
      unique case (op)
         op_rd, op_fadd: begin
            rsp_status <= st_ok;
            rsp_data   <= rd_word;
         end
         op_wr: begin
            rsp_status <= st_ok;
            rsp_data   <= '0;
         end
         // echo is handled only by the loopback exercisers
         default: begin
            rsp_status <= st_ur;
            rsp_data   <= '0;
         end
      endcase
   end

   // a selected request is answered on the next cycle, and nothing else is answered
   a_rsp_follows_sel : assert property (@(posedge clk) disable iff (rst)
      sel |=> rsp_valid);

   a_no_rsp_unsel : assert property (@(posedge clk) disable iff (rst)
      !sel |=> !rsp_valid);

endmodule : he_mem_engine

`default_nettype wire

//--- hdl/port_afu_instances.sv
`default_nettype none
`timescale 1ns/1ns

module port_afu_instances
   import afu_hdr_pkg::*, port_cfg_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 dec_valid,
   input  logic [num_ports-1:0] dec_sel,
   input  logic                 dec_err,
   input  opcode_t              dec_op,
   input  logic [addr_w-1:0]    dec_addr,
   input  logic [data_w-1:0]    dec_data,
   input  logic [tag_w-1:0]     dec_tag,
   output logic                 exe_valid,
   output opcode_t              exe_op,
   output status_t              exe_status,
   output logic [data_w-1:0]    exe_data,
   output logic [tag_w-1:0]     exe_tag
);

   logic [num_ports-1:0] rsp_valid;
   status_t              rsp_status [num_ports];
   logic [data_w-1:0]    rsp_data   [num_ports];
   logic [tag_w-1:0]     rsp_tag    [num_ports];
   logic                 err_valid;
   logic [tag_w-1:0]     err_tag;
   opcode_t              op_q;
   logic [1:0]           st_or;
   logic [data_w-1:0]    data_or;
   logic [tag_w-1:0]     tag_or;

   // ============================================================
   // one exerciser per port
   // ============================================================

   for (genvar j = 0; j < num_ports; j++) begin : he
      if (j != he_mem_idx) begin : lb
         he_lb_engine engine (
            .clk, .rst, .sel(dec_sel[j]), .op(dec_op), .addr(dec_addr),
            .data(dec_data), .tag(dec_tag), .rsp_valid(rsp_valid[j]),
            .rsp_status(rsp_status[j]), .rsp_data(rsp_data[j]), .rsp_tag(rsp_tag[j])
         );
      end else begin : mem
         he_mem_engine engine (
            .clk, .rst, .sel(dec_sel[j]), .op(dec_op), .addr(dec_addr),
            .data(dec_data), .tag(dec_tag), .rsp_valid(rsp_valid[j]),
            .rsp_status(rsp_status[j]), .rsp_data(rsp_data[j]), .rsp_tag(rsp_tag[j])
         );
      end
   end

   // a bad port skips the engines but takes the same single cycle through this stage
   always_ff @(posedge clk) begin
      if (rst) err_valid <= 1'b0;
      else     err_valid <= dec_valid && dec_err;
   end

   always_ff @(posedge clk) begin
      err_tag <= dec_tag;
      op_q    <= dec_op;
   end

   // ============================================================
   // response merge
   // ============================================================

   // at most one source is valid, so masking each one and ORing them acts as a mux
   always_comb begin
      st_or   = err_valid ? 2'(st_bad_port) : 2'b00;
      data_or = '0;
      tag_or  = err_valid ? err_tag : '0;
      for (int i = 0; i < num_ports; i++) begin
         st_or   = st_or | ({2{rsp_valid[i]}} & rsp_status[i]);
         data_or = data_or | ({data_w{rsp_valid[i]}} & rsp_data[i]);
         tag_or  = tag_or | ({tag_w{rsp_valid[i]}} & rsp_tag[i]);
      end
   end

   assign exe_valid  = err_valid || (rsp_valid != '0);
   assign exe_op     = op_q;
   assign exe_status = status_t'(st_or);
   assign exe_data   = data_or;
   assign exe_tag    = tag_or;

   // the one-hot OR only holds while the engines and the error path never answer together
   a_one_rsp : assert property (@(posedge clk) disable iff (rst)
      $onehot0({err_valid, rsp_valid}));

endmodule : port_afu_instances

`default_nettype wire

//--- hdl/port_cfg_pkg.sv
`default_nettype none

package port_cfg_pkg;

   // number of exerciser ports behind the decoder
   localparam int num_ports = 3;
   // the port field is wide enough to address one port past the last one
   localparam int port_w = 2;
   // this index holds the memory exerciser, and every other index is loopback
   localparam int he_mem_idx = 1;

   // local RAM of the memory exerciser
   localparam int mem_depth = 16;
   localparam int mem_aw    = 4;

   // scratch registers in each loopback exerciser
   localparam int num_scratch = 4;

endpackage : port_cfg_pkg

`default_nettype wire

//--- hdl/req_decoder.sv
`default_nettype none
`timescale 1ns/1ns

module req_decoder
   import afu_hdr_pkg::*, port_cfg_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 req_valid,
   input  logic [port_w-1:0]    req_port,
   input  opcode_t              req_op,
   input  logic [addr_w-1:0]    req_addr,
   input  logic [data_w-1:0]    req_data,
   input  logic [tag_w-1:0]     req_tag,
   output logic                 dec_valid,
   output logic [num_ports-1:0] dec_sel,
   output logic                 dec_err,
   output opcode_t              dec_op,
   output logic [addr_w-1:0]    dec_addr,
   output logic [data_w-1:0]    dec_data,
   output logic [tag_w-1:0]     dec_tag
);

   logic                 port_ok;
   logic [num_ports-1:0] sel_d;

   // ============================================================
   // port check and one-hot decode
   // ============================================================

   // every opcode value is legal here, and the engines reply st_ur
   // for the ones they do not handle
   assign port_ok = int'(req_port) < num_ports;

   // a port number past the last engine matches no select bit
   always_comb begin
      for (int i = 0; i < num_ports; i++) begin
         sel_d[i] = req_valid && (int'(req_port) == i);
      end
   end

   // the strobe, the selects and the error flag are cleared by reset
   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid <= 1'b0;
         dec_sel   <= '0;
         dec_err   <= 1'b0;
      end else begin
         dec_valid <= req_valid;
         dec_sel   <= sel_d;
         dec_err   <= req_valid && !port_ok;
      end
   end

   // the request fields are only meaningful while dec_valid is high
   always_ff @(posedge clk) begin
      dec_op   <= req_op;
      dec_addr <= req_addr;
      dec_data <= req_data;
      dec_tag  <= req_tag;
   end

   // every accepted request selects exactly one engine or flags a bad port
   a_sel_or_err : assert property (@(posedge clk) disable iff (rst)
      req_valid |=> dec_valid && ($onehot(dec_sel) ^ dec_err));

   // nothing is selected and no error is raised without a request
   a_sel_idle : assert property (@(posedge clk) disable iff (rst)
      !dec_valid |-> (dec_sel == '0) && !dec_err);

endmodule : req_decoder

`default_nettype wire

//--- src.f
hdl/afu_hdr_pkg.sv
hdl/port_cfg_pkg.sv
hdl/req_decoder.sv
hdl/he_lb_engine.sv
hdl/he_mem_engine.sv
hdl/port_afu_instances.sv
hdl/cpl_builder.sv
hdl/afu_top.sv
verif/tb_afu_top.sv

//--- verif/afu_stimulus.txt
# columns: name port opcode(0 rd 1 wr 2 echo 3 fadd) addr data tag, then expected channel
# (A completion, B commit, - idle) status(0 ok 1 ur 2 bad port) data, numbers in hex
rst_rd_lb0           0 0 03 00000000 01 A 0 00000000
rst_rd_mem           1 0 0a 00000000 02 A 0 00000000
idle                 0 0 00 00000000 00 - 0 00000000
lb0_wr               0 1 01 cafe0001 03 B 0 00000000
lb0_rd               0 0 01 00000000 04 A 0 cafe0001
lb2_wr               2 1 02 12345678 05 B 0 00000000
lb2_rd               2 0 02 00000000 06 A 0 12345678
lb0_rd_unwritten     0 0 02 00000000 07 A 0 00000000
lb2_rd_alias         2 0 06 00000000 08 A 0 12345678
idle                 0 0 00 00000000 00 - 0 00000000
lb0_echo             0 2 00 a5a5f00d 09 A 0 a5a5f00d
lb2_echo             2 2 7f 01020304 0a A 0 01020304
lb0_fadd_ur          0 3 01 00000005 0b A 1 00000000
lb2_fadd_ur          2 3 02 00000001 0c A 1 00000000
lb0_rd_after_fadd    0 0 01 00000000 0d A 0 cafe0001
idle                 0 0 00 00000000 00 - 0 00000000
mem_wr               1 1 05 00000064 0e B 0 00000000
mem_rd               1 0 05 00000000 0f A 0 00000064
mem_fadd             1 3 05 0000000a 10 A 0 00000064
mem_rd_sum           1 0 05 00000000 11 A 0 0000006e
mem_fadd_alias       1 3 15 00000002 12 A 0 0000006e
mem_rd_alias         1 0 05 00000000 13 A 0 00000070
mem_echo_ur          1 2 05 deadbeef 14 A 1 00000000
mem_wr_top           1 1 0f ffffffff 15 B 0 00000000
mem_fadd_wrap        1 3 0f 00000001 16 A 0 ffffffff
mem_rd_wrap          1 0 0f 00000000 17 A 0 00000000
idle                 0 0 00 00000000 00 - 0 00000000
bad_port_wr          3 1 00 11111111 18 A 2 00000000
bad_port_rd          3 0 00 00000000 19 A 2 00000000
bad_port_echo        3 2 00 abcdef01 1a A 2 00000000
b2b_p0_echo          0 2 00 00000aaa 1b A 0 00000aaa
b2b_p1_rd            1 0 05 00000000 1c A 0 00000070
b2b_p2_wr            2 1 03 00000bbb 1d B 0 00000000
b2b_bad_fadd         3 3 00 00000000 1e A 2 00000000
b2b_p2_rd            2 0 03 00000000 1f A 0 00000bbb
b2b_p1_wr            1 1 00 00000ccc 20 B 0 00000000

//--- verif/tb_afu_top.sv
`default_nettype none
`timescale 1ns/1ns

module tb_afu_top
   import afu_hdr_pkg::*, port_cfg_pkg::*;
();

   // ============================================================
   // run constants and DUT signals
   // ============================================================

   localparam int    max_lines = 64;
   // a request sampled at one rising edge leaves the DUT three edges later
   localparam int    pipe_lat  = 3;
   localparam string stim_path = "verif/afu_stimulus.txt";

   logic              clk;
   logic              rst;
   logic              req_valid;
   logic [port_w-1:0] req_port;
   opcode_t           req_op;
   logic [addr_w-1:0] req_addr;
   logic [data_w-1:0] req_data;
   logic [tag_w-1:0]  req_tag;
   logic              cpl_valid;
   logic [tag_w-1:0]  cpl_tag;
   status_t           cpl_status;
   logic [data_w-1:0] cpl_data;
   logic              commit_valid;
   logic [tag_w-1:0]  commit_tag;

   // one entry per stimulus line, idle lines included
   string       st_name   [max_lines];
   int          st_port   [max_lines];
   int          st_op     [max_lines];
   logic [31:0] st_addr   [max_lines];
   logic [31:0] st_data   [max_lines];
   logic [31:0] st_tag    [max_lines];
   logic [7:0]  st_chan   [max_lines];
   int          st_status [max_lines];
   logic [31:0] st_exp    [max_lines];
   int          num_lines;

   // expected outputs in request order
   // the cycle of an entry is the rising edge that sampled its request
   string       q_name   [$];
   logic [7:0]  q_chan   [$];
   int          q_status [$];
   logic [31:0] q_data   [$];
   logic [31:0] q_tag    [$];
   int          q_cycle  [$];

   int cycle       = 0;
   int cycle_limit = max_lines * 2 + 50;
   int error_count = 0;

   afu_top i_dut (
      .clk, .rst, .req_valid, .req_port, .req_op, .req_addr, .req_data, .req_tag,
      .cpl_valid, .cpl_tag, .cpl_status, .cpl_data, .commit_valid, .commit_tag
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // counts rising edges and ends a run that stops making progress
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= cycle_limit) begin
         abort_run($sformatf("timeout after %0d cycles with %0d outputs still expected",
                             cycle, q_name.size()));
      end
   end

   // ============================================================
   // helper tasks
   // ============================================================

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string test, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         error_count++;
         abort_run($sformatf("CHECK FAILED %s %s: expected %0h actual %0h",
                             test, field, expected, actual));
      end
   endtask

   // lines that do not hold all nine columns are comments or blank and are skipped
   task automatic load_stimulus();
      int               fd;
      int               n;
      reg [8*256-1:0]   line_buf;
      string            name;
      string            chan;
      int               port;
      int               op;
      int               status;
      logic [31:0]      addr;
      logic [31:0]      data;
      logic [31:0]      tag;
      logic [31:0]      exp_data;
      fd = $fopen(stim_path, "r");
      if (fd == 0) begin
         abort_run("the stimulus file could not be opened");
      end
      num_lines = 0;
      while (!$feof(fd)) begin
         line_buf = '0;
         n = $fgets(line_buf, fd);
         if (n > 0) begin
            n = $sscanf(line_buf, "%s %h %h %h %h %h %s %h %h", name, port, op, addr,
                        data, tag, chan, status, exp_data);
            if (n == 9) begin
               if (num_lines == max_lines) begin
                  abort_run("the stimulus file holds more lines than the testbench accepts");
               end
               st_name[num_lines]   = name;
               st_port[num_lines]   = port;
               st_op[num_lines]     = op;
               st_addr[num_lines]   = addr;
               st_data[num_lines]   = data;
               st_tag[num_lines]    = tag;
               st_chan[num_lines]   = chan[0];
               st_status[num_lines] = status;
               st_exp[num_lines]    = exp_data;
               num_lines++;
            end
         end
      end
      $fclose(fd);
   endtask

   // an idle line leaves req_valid low for one cycle
   task automatic drive_entry(input int idx);
      if (st_chan[idx] == "-") begin
         req_valid = 1'b0;
      end else begin
         req_valid = 1'b1;
         req_port  = st_port[idx][port_w-1:0];
         req_op    = opcode_t'(st_op[idx][1:0]);
         req_addr  = st_addr[idx][addr_w-1:0];
         req_data  = st_data[idx][data_w-1:0];
         req_tag   = st_tag[idx][tag_w-1:0];
         q_name.push_back(st_name[idx]);
         q_chan.push_back(st_chan[idx]);
         q_status.push_back(st_status[idx]);
         q_data.push_back(st_exp[idx]);
         q_tag.push_back(st_tag[idx]);
         q_cycle.push_back(cycle + 1);
      end
   endtask

   // called on the falling edge, when the registered outputs have settled
   task automatic check_outputs();
      string      name;
      logic [7:0] chan;
      int         status;
      logic [31:0] data;
      logic [31:0] tag;
      int         issued;
      if (cpl_valid && commit_valid) begin
         abort_run("the completion and the commit strobe were high in the same cycle");
      end
      if (cpl_valid || commit_valid) begin
         if (q_name.size() == 0) begin
            abort_run("an output appeared while no request was outstanding");
         end
         name   = q_name.pop_front();
         chan   = q_chan.pop_front();
         status = q_status.pop_front();
         data   = q_data.pop_front();
         tag    = q_tag.pop_front();
         issued = q_cycle.pop_front();
         // the host takes a registered output at the next rising edge
         check_value(name, "latency", issued + pipe_lat, cycle + 1);
         check_value(name, "channel", chan, commit_valid ? "B" : "A");
         if (commit_valid) begin
            check_value(name, "commit tag", tag, commit_tag);
         end else begin
            check_value(name, "tag", tag, cpl_tag);
            check_value(name, "status", status, cpl_status);
            check_value(name, "data", data, cpl_data);
         end
      end
   endtask

   // ============================================================
   // main sequence
   // ============================================================

   initial begin
      int idx;
      req_valid = 1'b0;
      req_port  = '0;
      req_op    = op_rd;
      req_addr  = '0;
      req_data  = '0;
      req_tag   = '0;
      rst       = 1'b1;
      load_stimulus();
      cycle_limit = num_lines * 2 + 50;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // one line per cycle
      // outputs of earlier lines are checked on the same falling edge
      for (idx = 0; idx < num_lines; idx++) begin
         check_outputs();
         drive_entry(idx);
         @(negedge clk);
      end
      req_valid = 1'b0;
      check_outputs();
      while (q_name.size() != 0) begin
         @(negedge clk);
         check_outputs();
      end
      // a few quiet cycles catch a stray output after the last expected one
      repeat (pipe_lat + 1) begin
         @(negedge clk);
         check_outputs();
      end
      if (error_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule : tb_afu_top

`default_nettype wire
